// ==== Bender.yml ====
package:
  name: speccy_kbd

sources:
  - target: any(rtl, test)
    files:
      - common/speccy_kbd_pkg.sv
      - ps2/ps2_rx.sv
      - design/scancode_framer.sv
      - keymap/keymap_store.sv
      - keymap/keymap_translator.sv
      - design/speccy_kbd_top.sv
  - target: test
    files:
      - verif/speccy_kbd_assertions.sv
      - verif/tb_speccy_kbd.sv

// ==== common/speccy_kbd_pkg.sv ====
package speccy_kbd_pkg;

    ////////////////////////////////////////
    // Keymap geometry
    ////////////////////////////////////////

    // Modifier state, extended flag and scan code
    localparam int KEYMAP_ADDR_W = 12;
    localparam int KEYMAP_DEPTH  = 1 << KEYMAP_ADDR_W;
    localparam int KEYMAP_DATA_W = 32;

    // PS/2 prefix bytes
    localparam logic [7:0] PS2_PREFIX_EXT = 8'hE0;
    localparam logic [7:0] PS2_PREFIX_REL = 8'hF0;

    ////////////////////////////////////////
    // Keymap word
    ////////////////////////////////////////

    typedef struct packed {
        // One bit per half-row touched by the key
        logic [7:0] key_row;
        // Column bits, active high in the map
        logic [4:0] key_col;
        logic [2:0] key_mod;
        // Master reset, user reset, NMI
        logic [2:0] key_sig;
        // Up, down, left, right, fire
        logic [4:0] key_joy;
        logic [7:0] key_tog;
    } keymap_entry_t;

    ////////////////////////////////////////
    // Key event from the framer
    ////////////////////////////////////////

    typedef struct packed {
        logic [7:0] scan;
        logic       extended;
        logic       released;
    } key_event_t;

    ////////////////////////////////////////
    // Wishbone classic request, host side
    ////////////////////////////////////////

    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [KEYMAP_ADDR_W-1:0] adr;
        logic [KEYMAP_DATA_W-1:0] dat_w;
    } wb_req_t;

endpackage

// ==== design/scancode_framer.sv ====
`timescale 1ns/1ps

module scancode_framer
    import speccy_kbd_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    output logic       ev_valid,
    output key_event_t ev
);

    logic ext_pend;
    logic rel_pend;
    logic is_ext;
    logic is_rel;
    logic is_code;

    assign is_ext  = (byte_data == PS2_PREFIX_EXT);
    assign is_rel  = (byte_data == PS2_PREFIX_REL);
    assign is_code = byte_valid & ~is_ext & ~is_rel;

    // Prefix flags live until the next code byte
    always_ff @(posedge clk) begin
        if (rst) begin
            ext_pend <= 1'b0;
            rel_pend <= 1'b0;
            ev_valid <= 1'b0;
        end else begin
            ev_valid <= is_code;
            if (byte_valid) begin
                if (is_ext) begin
                    ext_pend <= 1'b1;
                end else if (is_rel) begin
                    rel_pend <= 1'b1;
                end else begin
                    ext_pend <= 1'b0;
                    rel_pend <= 1'b0;
                end
            end
        end
    end

    // Event payload
    always_ff @(posedge clk) begin
        if (is_code) begin
            ev.scan     <= byte_data;
            ev.extended <= ext_pend;
            ev.released <= rel_pend;
        end
    end

endmodule

// ==== design/speccy_kbd_top.sv ====
`timescale 1ns/1ps

module speccy_kbd_top
    import speccy_kbd_pkg::*;
#(
    parameter int PS2_SYNC_STAGES = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        ps2_clk,
    input  logic        ps2_data,
    input  wb_req_t     wb_req,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    input  logic [7:0]  sp_row,
    output logic [4:0]  sp_col,
    output logic        master_reset,
    output logic        user_reset,
    output logic        user_nmi,
    output logic [4:0]  joy,
    output logic [7:0]  user_toggles
);

    logic                     byte_valid;
    logic [7:0]               byte_data;
    logic                     ev_valid;
    key_event_t               ev;
    logic [KEYMAP_ADDR_W-1:0] lookup_addr;
    keymap_entry_t            lookup_data;

    // Keyboard lines to bytes
    ps2_rx #(
        .PS2_SYNC_STAGES(PS2_SYNC_STAGES)
    ) ps2_rx_i (
        .clk       (clk),
        .rst       (rst),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .byte_valid(byte_valid),
        .byte_data (byte_data)
    );

    scancode_framer scancode_framer_i (
        .clk       (clk),
        .rst       (rst),
        .byte_valid(byte_valid),
        .byte_data (byte_data),
        .ev_valid  (ev_valid),
        .ev        (ev)
    );

    // Keymap shared by host and translator
    keymap_store keymap_store_i (
        .clk        (clk),
        .rst        (rst),
        .wb_req     (wb_req),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .lookup_addr(lookup_addr),
        .lookup_data(lookup_data)
    );

    keymap_translator keymap_translator_i (
        .clk         (clk),
        .rst         (rst),
        .ev_valid    (ev_valid),
        .ev          (ev),
        .lookup_addr (lookup_addr),
        .lookup_data (lookup_data),
        .sp_row      (sp_row),
        .sp_col      (sp_col),
        .master_reset(master_reset),
        .user_reset  (user_reset),
        .user_nmi    (user_nmi),
        .joy         (joy),
        .user_toggles(user_toggles)
    );

endmodule

// ==== keymap/keymap_store.sv ====
`timescale 1ns/1ps

module keymap_store
    import speccy_kbd_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  wb_req_t                  wb_req,
    output logic [KEYMAP_DATA_W-1:0] wb_dat_r,
    output logic                     wb_ack,
    input  logic [KEYMAP_ADDR_W-1:0] lookup_addr,
    output keymap_entry_t            lookup_data
);

    // Empty map after configuration
    logic [KEYMAP_DATA_W-1:0] mem [KEYMAP_DEPTH] = '{default: '0};

    logic wb_hit;

    ////////////////////////////////////////
    // Wishbone port
    ////////////////////////////////////////

    // Accept once per strobe, the ack cycle blocks a second hit
    assign wb_hit = wb_req.cyc & wb_req.stb & ~wb_ack;

    always_ff @(posedge clk) begin
        if (rst)
            wb_ack <= 1'b0;
        else
            wb_ack <= wb_hit;
    end

    // Read data lines up with ack
    always_ff @(posedge clk) begin
        if (wb_hit) begin
            if (wb_req.we)
                mem[wb_req.adr] <= wb_req.dat_w;
            wb_dat_r <= mem[wb_req.adr];
        end
    end

    ////////////////////////////////////////
    // Lookup port
    ////////////////////////////////////////

    // Read only, one clock latency
    always_ff @(posedge clk) begin
        lookup_data <= keymap_entry_t'(mem[lookup_addr]);
    end

endmodule

// ==== keymap/keymap_translator.sv ====
`timescale 1ns/1ps

module keymap_translator
    import speccy_kbd_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ev_valid,
    input  key_event_t               ev,
    output logic [KEYMAP_ADDR_W-1:0] lookup_addr,
    input  keymap_entry_t            lookup_data,
    input  logic [7:0]               sp_row,
    output logic [4:0]               sp_col,
    output logic                     master_reset,
    output logic                     user_reset,
    output logic                     user_nmi,
    output logic [4:0]               joy,
    output logic [7:0]               user_toggles
);

    typedef enum logic [1:0] {
        CLEAN,
        IDLE,
        ADDR,
        XLATE
    } state_t;

    state_t          state;
    // Half-rows, active low like the real matrix
    logic [7:0][4:0] rows;
    logic [2:0]      mods;
    logic [2:0]      sig;
    logic            rel_q;

    assign {master_reset, user_reset, user_nmi} = sig;

    ////////////////////////////////////////
    // Lookup sequence
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= CLEAN;
            rows         <= '1;
            mods         <= '0;
            sig          <= '0;
            joy          <= '0;
            user_toggles <= '0;
        end else begin
            case (state)
                CLEAN: begin
                    rows         <= '1;
                    mods         <= '0;
                    sig          <= '0;
                    joy          <= '0;
                    user_toggles <= '0;
                    state        <= IDLE;
                end
                IDLE: begin
                    if (ev_valid)
                        state <= ADDR;
                end
                // RAM output registers this cycle
                ADDR: begin
                    state <= XLATE;
                end
                XLATE: begin
                    for (int r = 0; r < 8; r++) begin
                        if (lookup_data.key_row[r]) begin
                            if (rel_q)
                                rows[r] <= rows[r] | lookup_data.key_col;
                            else
                                rows[r] <= rows[r] & ~lookup_data.key_col;
                        end
                    end
                    // Release clears what the press set
                    if (rel_q) begin
                        mods         <= mods & ~lookup_data.key_mod;
                        sig          <= sig & ~lookup_data.key_sig;
                        joy          <= joy & ~lookup_data.key_joy;
                        user_toggles <= user_toggles & ~lookup_data.key_tog;
                    end else begin
                        mods         <= mods | lookup_data.key_mod;
                        sig          <= sig | lookup_data.key_sig;
                        joy          <= joy | lookup_data.key_joy;
                        user_toggles <= user_toggles | lookup_data.key_tog;
                    end
                    state <= IDLE;
                end
                default: begin
                    state <= CLEAN;
                end
            endcase
        end
    end

    // Address uses the modifiers held at event time
    always_ff @(posedge clk) begin
        if (state == IDLE && ev_valid) begin
            lookup_addr <= {mods, ev.extended, ev.scan};
            rel_q       <= ev.released;
        end
    end

    ////////////////////////////////////////
    // CPU side column read
    ////////////////////////////////////////

    // Several selected rows read as their AND
    always_comb begin
        sp_col = '1;
        for (int r = 0; r < 8; r++) begin
            if (!sp_row[r])
                sp_col &= rows[r];
        end
    end

endmodule

// ==== ps2/ps2_rx.sv ====
`timescale 1ns/1ps

module ps2_rx #(
    parameter int PS2_SYNC_STAGES = 2
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic       byte_valid,
    output logic [7:0] byte_data
);

    // Clocks without a keyboard edge before a partial frame is dropped
    localparam int IDLE_W = 12;

    logic [PS2_SYNC_STAGES-1:0] clk_sync;
    logic [PS2_SYNC_STAGES-1:0] data_sync;
    logic                       clk_prev;
    logic                       clk_fall;
    logic                       data_bit;
    logic                       frame_ok;
    logic [3:0]                 bit_cnt;
    logic [9:0]                 shreg;
    logic [IDLE_W-1:0]          idle_cnt;

    ////////////////////////////////////////
    // Synchronizers and edge detect
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync  <= '1;
            data_sync <= '1;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync[0]  <= ps2_clk;
            data_sync[0] <= ps2_data;
            for (int i = 1; i < PS2_SYNC_STAGES; i++) begin
                clk_sync[i]  <= clk_sync[i-1];
                data_sync[i] <= data_sync[i-1];
            end
            clk_prev <= clk_sync[PS2_SYNC_STAGES-1];
        end
    end

    // Keyboard changes data on the rising edge, so sample on the falling one
    assign clk_fall = clk_prev & ~clk_sync[PS2_SYNC_STAGES-1];
    assign data_bit = data_sync[PS2_SYNC_STAGES-1];

    // Start low, stop high, odd parity over data plus parity bit
    assign frame_ok = ~shreg[0] & data_bit & (^shreg[9:1]);

    ////////////////////////////////////////
    // Bit counter and frame check
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt    <= '0;
            idle_cnt   <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (clk_fall) begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd10) begin
                    bit_cnt    <= '0;
                    byte_valid <= frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt != '0) begin
                // Stuck mid-frame, resync on the next start bit
                if (&idle_cnt) begin
                    bit_cnt  <= '0;
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    // LSB first, start bit ends up in shreg[0]
    always_ff @(posedge clk) begin
        if (clk_fall) begin
            shreg <= {data_bit, shreg[9:1]};
            if (bit_cnt == 4'd10)
                byte_data <= shreg[8:1];
        end
    end

endmodule

// ==== src.f ====
common/speccy_kbd_pkg.sv
ps2/ps2_rx.sv
design/scancode_framer.sv
keymap/keymap_store.sv
keymap/keymap_translator.sv
design/speccy_kbd_top.sv
verif/speccy_kbd_assertions.sv
verif/tb_speccy_kbd.sv

// ==== verif/speccy_kbd_assertions.sv ====
`timescale 1ns/1ps

module speccy_kbd_assertions #(
    // Wishbone checks in the store, event and reset checks in the translator
    parameter bit WB_SIDE = 1'b0
) (
    input logic        clk,
    input logic        rst,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic        wb_ack,
    input logic        ev_valid,
    input logic        in_idle,
    input logic [15:0] ctrl
);

    // Read from the testbench top
    int unsigned fail_count = 0;

    if (WB_SIDE) begin : g_wb

        ////////////////////////////////////////
        // Wishbone classic
        ////////////////////////////////////////

        ack_after_strobe: assert property (@(posedge clk) disable iff (rst)
            wb_ack |-> $past(wb_cyc && wb_stb)) else begin
            $error("wb_ack without cyc and stb in the previous cycle");
            fail_count++;
        end

        ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
            wb_ack |=> !wb_ack) else begin
            $error("wb_ack held for more than one cycle");
            fail_count++;
        end

    end else begin : g_ev

        ////////////////////////////////////////
        // Key events and reset
        ////////////////////////////////////////

        // Translator never busy when an event shows up
        event_when_idle: assert property (@(posedge clk) disable iff (rst)
            ev_valid |-> in_idle) else begin
            $error("ev_valid while the translator was busy");
            fail_count++;
        end

        ctrl_low_after_reset: assert property (@(posedge clk)
            $fell(rst) |-> (ctrl == '0)) else begin
            $error("control outputs not low in the cycle after reset");
            fail_count++;
        end

    end

endmodule

bind keymap_store speccy_kbd_assertions #(.WB_SIDE(1'b1)) wb_checks_i (
    .clk     (clk),
    .rst     (rst),
    .wb_cyc  (wb_req.cyc),
    .wb_stb  (wb_req.stb),
    .wb_ack  (wb_ack),
    .ev_valid(1'b0),
    .in_idle (1'b1),
    .ctrl    (16'h0000)
);

bind keymap_translator speccy_kbd_assertions #(.WB_SIDE(1'b0)) ev_checks_i (
    .clk     (clk),
    .rst     (rst),
    .wb_cyc  (1'b0),
    .wb_stb  (1'b0),
    .wb_ack  (1'b0),
    .ev_valid(ev_valid),
    .in_idle (state == IDLE),
    .ctrl    ({master_reset, user_reset, user_nmi, joy, user_toggles})
);

// ==== verif/tb_speccy_kbd.sv ====
`timescale 1ns/1ps

module tb_speccy_kbd
    import speccy_kbd_pkg::*;
();

    localparam int RESET_CYCLES = 16;
    localparam int CHECK_MARGIN = 8;
    // About 35 frames of 90 clocks plus bus and check cycles, times ten
    localparam int CYCLE_LIMIT  = 40000;

    logic        clk, rst, ps2_clk, ps2_data, wb_ack;
    logic        master_reset, user_reset, user_nmi;
    wb_req_t     wb_req;
    logic [31:0] wb_dat_r, rdata;
    logic [7:0]  sp_row, user_toggles, scan;
    logic [4:0]  sp_col, joy;

    // Expected state
    logic [31:0] map_m [KEYMAP_DEPTH];
    logic [4:0]  rows_m [8];
    logic [2:0]  mods_m, sig_m;
    logic [4:0]  joy_m;
    logic [7:0]  tog_m;
    string       test_name;
    integer      seed, rnd;
    int unsigned cycle_count = 0;
    logic [KEYMAP_ADDR_W-1:0] wb_addrs [4] = '{12'h0AB, 12'h1AB, 12'h800, 12'hFFF};

    speccy_kbd_top #(.PS2_SYNC_STAGES(2)) speccy_kbd_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the run did not complete", cycle_count);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

    function automatic int unsigned bound_failures();
        return speccy_kbd_top_i.keymap_store_i.wb_checks_i.fail_count
             + speccy_kbd_top_i.keymap_translator_i.ev_checks_i.fail_count;
    endfunction

    always @(negedge clk) begin
        assert (bound_failures() == 0) else begin
            $display("A bound protocol assertion failed inside the DUT");
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic expect_equal(input string what, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            $display("[ERROR] %s, %s: expected 0x%0h, actual 0x%0h",
                     test_name, what, exp_v, act_v);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    // Selected rows read as their AND
    task automatic check_select(input logic [7:0] pat);
        logic [4:0] col;
        col = '1;
        for (int r = 0; r < 8; r++) begin
            if (!pat[r])
                col &= rows_m[r];
        end
        @(posedge clk);
        sp_row <= pat;
        @(negedge clk);
        expect_equal($sformatf("sp_col at sp_row %02h", pat), col, sp_col);
    endtask

    task automatic compare_state();
        check_select(8'hFF);
        check_select(8'h00);
        check_select(8'hF9);
        for (int r = 0; r < 8; r++)
            check_select(8'(~(8'h01 << r)));
        expect_equal("signals", sig_m, {master_reset, user_reset, user_nmi});
        expect_equal("joystick", joy_m, joy);
        expect_equal("toggles", tog_m, user_toggles);
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // Start, 8 data bits LSB first, odd parity, stop; 8 clocks per bit
    task automatic drive_frame(input logic [7:0] data, input logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            ps2_data <= frame[i];
            repeat (2) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (4) @(posedge clk);
            ps2_clk <= 1'b1;
            @(posedge clk);
        end
        @(posedge clk);
        ps2_data <= 1'b1;
        repeat (4) @(posedge clk);
    endtask

    task automatic access_bus(input logic write, input logic [KEYMAP_ADDR_W-1:0] addr,
                              input logic [31:0] wdata);
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: write, adr: addr, dat_w: wdata};
        do
            @(negedge clk);
        while (!wb_ack);
        rdata = wb_dat_r;
        @(posedge clk);
        wb_req <= '0;
        if (write)
            map_m[addr] = wdata;
    endtask

    function automatic logic [31:0] make_entry(input logic [7:0] row, input logic [4:0] col,
            input logic [2:0] mod, input logic [2:0] sig, input logic [4:0] jb,
            input logic [7:0] tog);
        keymap_entry_t e;
        e = '{key_row: row, key_col: col, key_mod: mod, key_sig: sig, key_joy: jb, key_tog: tog};
        return e;
    endfunction

    // Sends prefixes and code, then updates the expected state
    task automatic key_event(input logic ext, input logic rel, input logic [7:0] code);
        keymap_entry_t e;
        if (ext)
            drive_frame(PS2_PREFIX_EXT, 1'b0);
        if (rel)
            drive_frame(PS2_PREFIX_REL, 1'b0);
        drive_frame(code, 1'b0);
        // Modifiers held before the event pick the entry
        e = keymap_entry_t'(map_m[{mods_m, ext, code}]);
        for (int r = 0; r < 8; r++) begin
            if (e.key_row[r])
                rows_m[r] = rel ? (rows_m[r] | e.key_col) : (rows_m[r] & ~e.key_col);
        end
        mods_m = rel ? (mods_m & ~e.key_mod) : (mods_m | e.key_mod);
        sig_m  = rel ? (sig_m & ~e.key_sig) : (sig_m | e.key_sig);
        joy_m  = rel ? (joy_m & ~e.key_joy) : (joy_m | e.key_joy);
        tog_m  = rel ? (tog_m & ~e.key_tog) : (tog_m | e.key_tog);
        repeat (CHECK_MARGIN) @(posedge clk);
        compare_state();
    endtask

    initial begin
        rst      = 1'b1;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        wb_req   = '0;
        sp_row   = 8'hFF;
        seed     = 32'hc6cf0216;
        for (int a = 0; a < KEYMAP_DEPTH; a++)
            map_m[a] = '0;
        for (int r = 0; r < 8; r++)
            rows_m[r] = 5'h1F;
        {mods_m, sig_m, joy_m, tog_m} = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        test_name = "reset";
        for (int p = 0; p < 256; p++)
            check_select(8'(p));
        compare_state();

        test_name = "wishbone";
        foreach (wb_addrs[i])
            access_bus(1'b1, wb_addrs[i], {wb_addrs[i], 8'h5A, wb_addrs[i]});
        foreach (wb_addrs[i]) begin
            access_bus(1'b0, wb_addrs[i], '0);
            expect_equal($sformatf("read %03h", wb_addrs[i]),
                         {wb_addrs[i], 8'h5A, wb_addrs[i]}, rdata);
        end

        // A in half-row 1, Q in half-row 2
        test_name = "matrix";
        access_bus(1'b1, {3'd0, 1'b0, 8'h1C}, make_entry(8'h02, 5'h01, 0, 0, 0, 0));
        access_bus(1'b1, {3'd0, 1'b0, 8'h15}, make_entry(8'h04, 5'h01, 0, 0, 0, 0));
        key_event(1'b0, 1'b0, 8'h1C);
        key_event(1'b0, 1'b0, 8'h15);
        key_event(1'b0, 1'b1, 8'h1C);
        key_event(1'b0, 1'b1, 8'h15);

        test_name = "extended";
        access_bus(1'b1, {3'd0, 1'b0, 8'h75}, make_entry(8'h10, 5'h08, 0, 0, 0, 0));
        access_bus(1'b1, {3'd0, 1'b1, 8'h75}, make_entry(8'h00, 5'h00, 0, 0, 5'h10, 0));
        key_event(1'b1, 1'b0, 8'h75);
        key_event(1'b1, 1'b1, 8'h75);
        key_event(1'b0, 1'b0, 8'h75);
        key_event(1'b0, 1'b1, 8'h75);

        // Shift entry at both addresses so its release finds it
        test_name = "modifier";
        access_bus(1'b1, {3'd0, 1'b0, 8'h12}, make_entry(8'h01, 5'h01, 3'd1, 0, 0, 0));
        access_bus(1'b1, {3'd1, 1'b0, 8'h12}, make_entry(8'h01, 5'h01, 3'd1, 0, 0, 0));
        access_bus(1'b1, {3'd0, 1'b0, 8'h3C}, make_entry(8'h80, 5'h02, 0, 0, 0, 0));
        access_bus(1'b1, {3'd1, 1'b0, 8'h3C}, make_entry(8'h00, 5'h00, 0, 3'd1, 0, 8'h04));
        key_event(1'b0, 1'b0, 8'h12);
        key_event(1'b0, 1'b0, 8'h3C);
        expect_equal("nmi raised", 1, user_nmi);
        key_event(1'b0, 1'b1, 8'h3C);
        key_event(1'b0, 1'b1, 8'h12);

        test_name = "ignored";
        drive_frame(8'h1C, 1'b1);
        repeat (CHECK_MARGIN) @(posedge clk);
        compare_state();
        for (int i = 0; i < 4; i++) begin
            do begin
                rnd  = $random(seed);
                scan = rnd[7:0];
            end while (scan == PS2_PREFIX_EXT || scan == PS2_PREFIX_REL
                       || map_m[{mods_m, 1'b0, scan}] != '0);
            key_event(1'b0, 1'b0, scan);
            key_event(1'b0, 1'b1, scan);
        end

        if (bound_failures() == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

endmodule
